// ==== source/fib_pkg.sv ====
// FIB geometry and state encodings; prefix length counts MSB-aligned bits, 0 to 63, so 64 is not expressible
`default_nettype none

package fib_pkg;

    // Name prefix and its declared length
    localparam int prefix_w = 64;
    localparam int len_w    = 6;

    // Slot index produced by the XOR fold
    localparam int hash_w = 6;

    // Link bytes
    localparam int byte_w       = 8;
    localparam int prefix_bytes = 8;
    // Metadata, full prefix and matched prefix
    localparam int tx_bytes     = 17;
    localparam int tx_w         = tx_bytes * byte_w;

    // Valid table is one row of slots per prefix length
    localparam int num_lengths = 1 << len_w;
    localparam int num_slots   = 1 << hash_w;

    // Fold chunks, the top one only partly filled
    localparam int hash_chunks = (prefix_w + hash_w - 1) / hash_w;

    // Byte counters
    localparam int rx_cnt_w = $clog2(prefix_bytes);
    localparam int tx_cnt_w = $clog2(tx_bytes);

    typedef logic [len_w-1:0]    len_t;
    typedef logic [rx_cnt_w-1:0] rx_cnt_t;
    typedef logic [tx_cnt_w-1:0] tx_cnt_t;

    localparam rx_cnt_t rx_last = rx_cnt_t'(prefix_bytes - 1);
    localparam tx_cnt_t tx_last = tx_cnt_t'(tx_bytes - 1);

    // Incoming SPI parser
    typedef enum logic [1:0] {
        rx_idle,
        rx_metadata,
        rx_prefix
    } rx_state_t;

    // Longest-prefix-match search
    typedef enum logic [1:0] {
        lpm_idle,
        lpm_probe,
        lpm_wait_hit,
        lpm_hold_result
    } lpm_state_t;

    // Result serializer
    typedef enum logic {
        tx_idle,
        tx_send
    } tx_state_t;

endpackage

`default_nettype wire

// ==== source/prefix_hash.sv ====
// Registered XOR fold of a length-masked prefix; one cycle latency, collisions give false hits
`default_nettype none
`timescale 1ns/1ps

module prefix_hash (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [fib_pkg::prefix_w-1:0] prefix,
    input  logic [fib_pkg::len_w-1:0]    len,
    output logic [fib_pkg::hash_w-1:0]   hash
);

    logic [fib_pkg::prefix_w-1:0] mask;
    logic [fib_pkg::prefix_w-1:0] masked;
    logic [fib_pkg::prefix_w-1:0] chunk;
    logic [fib_pkg::hash_w-1:0]   fold;

    // Keep only the top len bits, len of 0 clears everything
    assign mask   = ~({fib_pkg::prefix_w{1'b1}} >> len);
    assign masked = prefix & mask;

    // Fold 6-bit chunks from bit 0 upward
    // Top chunk holds bits 63 to 60 with zeros above
    always_comb begin
        fold  = '0;
        chunk = '0;
        for (int i = 0; i < fib_pkg::hash_chunks; i++) begin
            chunk = masked >> (i * fib_pkg::hash_w);
            fold  = fold ^ chunk[fib_pkg::hash_w-1:0];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hash <= '0;
        end else begin
            hash <= fold;
        end
    end

endmodule

`default_nettype wire

// ==== source/fib_valid_table.sv ====
// Valid bits per length and hash slot; a learn lands 2 cycles after learn_en, lookup_hit 1 cycle after lookup
`default_nettype none
`timescale 1ns/1ps

module fib_valid_table (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         learn_en,
    input  logic [fib_pkg::prefix_w-1:0] learn_prefix,
    input  logic [fib_pkg::len_w-1:0]    learn_len,
    input  logic [fib_pkg::prefix_w-1:0] lookup_prefix,
    input  logic [fib_pkg::len_w-1:0]    lookup_len,
    output logic                         lookup_hit
);

    logic [fib_pkg::hash_w-1:0]    learn_hash;
    logic [fib_pkg::hash_w-1:0]    lookup_hash;
    logic                          learn_en_d;
    logic [fib_pkg::len_w-1:0]     learn_len_d;
    logic [fib_pkg::len_w-1:0]     lookup_len_d;
    logic [fib_pkg::num_slots-1:0] valid_bits [fib_pkg::num_lengths];

    // Separate hash units so learn and lookup never share a cycle
    prefix_hash u_learn_hash (
        .clk    (clk),
        .rst    (rst),
        .prefix (learn_prefix),
        .len    (learn_len),
        .hash   (learn_hash)
    );

    prefix_hash u_lookup_hash (
        .clk    (clk),
        .rst    (rst),
        .prefix (lookup_prefix),
        .len    (lookup_len),
        .hash   (lookup_hash)
    );

    // Lengths follow their hash through the same register stage
    always_ff @(posedge clk) begin
        learn_len_d  <= learn_len;
        lookup_len_d <= lookup_len;
    end

    // Write enable lines up with the registered learn hash
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            learn_en_d <= 1'b0;
            for (int i = 0; i < fib_pkg::num_lengths; i++) begin
                valid_bits[i] <= '0;
            end
        end else begin
            learn_en_d <= learn_en;
            if (learn_en_d) begin
                valid_bits[learn_len_d][learn_hash] <= 1'b1;
            end
        end
    end

    // Read at the registered slot and delayed length
    assign lookup_hit = valid_bits[lookup_len_d][lookup_hash];

endmodule

`default_nettype wire

// ==== source/prefix_rx.sv ====
// SPI interest parser; rx_valid opens a packet, then metadata and 8 prefix bytes MSB first, one per cycle
`default_nettype none
`timescale 1ns/1ps

module prefix_rx (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         rx_valid,
    input  logic [fib_pkg::byte_w-1:0]   data_spi_to_fib,
    output logic [fib_pkg::prefix_w-1:0] pit_out_prefix,
    output logic [fib_pkg::byte_w-1:0]   pit_out_metadata,
    output logic                         prefix_ready,
    output logic                         learn_en,
    output logic [fib_pkg::prefix_w-1:0] learn_prefix,
    output logic [fib_pkg::len_w-1:0]    learn_len
);

    fib_pkg::rx_state_t           state;
    fib_pkg::rx_cnt_t             byte_cnt;
    logic [fib_pkg::byte_w-1:0]   meta_q;
    logic [fib_pkg::prefix_w-1:0] shift_q;
    logic                         last_byte;

    // Final prefix byte is on the bus this cycle
    assign last_byte = (state == fib_pkg::rx_prefix) && (byte_cnt == fib_pkg::rx_last);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state        <= fib_pkg::rx_idle;
            byte_cnt     <= '0;
            prefix_ready <= 1'b0;
        end else begin
            // Single cycle pulse
            prefix_ready <= 1'b0;
            case (state)
                fib_pkg::rx_idle: begin
                    if (rx_valid) begin
                        state <= fib_pkg::rx_metadata;
                    end
                end
                fib_pkg::rx_metadata: begin
                    byte_cnt <= '0;
                    state    <= fib_pkg::rx_prefix;
                end
                fib_pkg::rx_prefix: begin
                    byte_cnt <= byte_cnt + fib_pkg::rx_cnt_t'(1);
                    if (last_byte) begin
                        prefix_ready <= 1'b1;
                        state        <= fib_pkg::rx_idle;
                    end
                end
                default: begin
                    state <= fib_pkg::rx_idle;
                end
            endcase
        end
    end

    // Byte capture and PIT outputs, held until the next packet completes
    always_ff @(posedge clk) begin
        if (state == fib_pkg::rx_metadata) begin
            meta_q <= data_spi_to_fib;
        end
        if (state == fib_pkg::rx_prefix) begin
            shift_q <= {shift_q[fib_pkg::prefix_w-fib_pkg::byte_w-1:0], data_spi_to_fib};
        end
        if (last_byte) begin
            pit_out_prefix   <= {shift_q[fib_pkg::prefix_w-fib_pkg::byte_w-1:0], data_spi_to_fib};
            pit_out_metadata <= meta_q;
        end
    end

    // Learn request rides on the PIT pulse
    // Length sits in metadata bits 5 to 0
    assign learn_en     = prefix_ready;
    assign learn_prefix = pit_out_prefix;
    assign learn_len    = pit_out_metadata[fib_pkg::len_w-1:0];

endmodule

`default_nettype wire

// ==== source/lpm_search.sv ====
// LPM from the declared length down to 0 at 2 cycles per probe; hash collisions can false-hit
`default_nettype none
`timescale 1ns/1ps

module lpm_search (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         fib_out_bit,
    input  logic [fib_pkg::prefix_w-1:0] pit_in_prefix,
    input  logic [fib_pkg::byte_w-1:0]   pit_in_metadata,
    input  logic                         lookup_hit,
    output logic [fib_pkg::prefix_w-1:0] lookup_prefix,
    output logic [fib_pkg::len_w-1:0]    lookup_len,
    input  logic                         tx_busy,
    output logic                         result_valid,
    output logic [fib_pkg::byte_w-1:0]   result_metadata,
    output logic [fib_pkg::prefix_w-1:0] result_total,
    output logic [fib_pkg::prefix_w-1:0] result_match
);

    fib_pkg::lpm_state_t          state;
    fib_pkg::len_t                len_q;
    logic [fib_pkg::prefix_w-1:0] total_q;
    logic [fib_pkg::prefix_w-1:0] match_q;
    logic [fib_pkg::byte_w-1:0]   meta_q;
    logic [fib_pkg::prefix_w-1:0] len_mask;
    logic                         done;

    // Top len_q bits of the prefix
    assign len_mask = ~({fib_pkg::prefix_w{1'b1}} >> len_q);

    // Search ends on a hit or after the length 0 probe
    assign done = (state == fib_pkg::lpm_wait_hit) && (lookup_hit || (len_q == '0));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= fib_pkg::lpm_idle;
            len_q <= '0;
        end else begin
            case (state)
                fib_pkg::lpm_idle: begin
                    if (fib_out_bit) begin
                        len_q <= pit_in_metadata[fib_pkg::len_w-1:0];
                        state <= fib_pkg::lpm_probe;
                    end
                end
                fib_pkg::lpm_probe: begin
                    // Table registers the probe this edge
                    state <= fib_pkg::lpm_wait_hit;
                end
                fib_pkg::lpm_wait_hit: begin
                    if (done) begin
                        state <= fib_pkg::lpm_hold_result;
                    end else begin
                        // One bit shorter, try again
                        len_q <= len_q - fib_pkg::len_t'(1);
                        state <= fib_pkg::lpm_probe;
                    end
                end
                fib_pkg::lpm_hold_result: begin
                    // Wait for the serializer to drain
                    if (!tx_busy) begin
                        state <= fib_pkg::lpm_idle;
                    end
                end
                default: begin
                    state <= fib_pkg::lpm_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == fib_pkg::lpm_idle) && fib_out_bit) begin
            total_q <= pit_in_prefix;
            meta_q  <= pit_in_metadata;
        end
        // Length 0 has an empty mask, so a miss all the way down reports zeros
        if (done) begin
            match_q <= total_q & len_mask;
        end
    end

    // Table masks the prefix itself, so the full prefix goes out
    assign lookup_prefix = total_q;
    assign lookup_len    = len_q;

    // Valid only in the handoff cycle
    assign result_valid    = (state == fib_pkg::lpm_hold_result) && !tx_busy;
    assign result_metadata = meta_q;
    assign result_total    = total_q;
    assign result_match    = match_q;

endmodule

`default_nettype wire

// ==== source/spi_result_tx.sv ====
// Result serializer; 17 bytes MSB first, flag high for exactly those cycles, no stall once started
`default_nettype none
`timescale 1ns/1ps

module spi_result_tx (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         result_valid,
    input  logic [fib_pkg::byte_w-1:0]   result_metadata,
    input  logic [fib_pkg::prefix_w-1:0] result_total,
    input  logic [fib_pkg::prefix_w-1:0] result_match,
    output logic                         tx_busy,
    output logic                         fib_to_spi_data_flag,
    output logic [fib_pkg::byte_w-1:0]   data_fib_to_spi
);

    fib_pkg::tx_state_t       state;
    fib_pkg::tx_cnt_t         byte_cnt;
    logic [fib_pkg::tx_w-1:0] shift_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= fib_pkg::tx_idle;
            byte_cnt <= '0;
        end else begin
            case (state)
                fib_pkg::tx_idle: begin
                    if (result_valid) begin
                        byte_cnt <= '0;
                        state    <= fib_pkg::tx_send;
                    end
                end
                fib_pkg::tx_send: begin
                    byte_cnt <= byte_cnt + fib_pkg::tx_cnt_t'(1);
                    if (byte_cnt == fib_pkg::tx_last) begin
                        state <= fib_pkg::tx_idle;
                    end
                end
                default: begin
                    state <= fib_pkg::tx_idle;
                end
            endcase
        end
    end

    // Metadata first, then full prefix, then matched prefix
    always_ff @(posedge clk) begin
        if ((state == fib_pkg::tx_idle) && result_valid) begin
            shift_q <= {result_metadata, result_total, result_match};
        end else if (state == fib_pkg::tx_send) begin
            shift_q <= shift_q << fib_pkg::byte_w;
        end
    end

    assign tx_busy              = (state != fib_pkg::tx_idle);
    assign fib_to_spi_data_flag = (state == fib_pkg::tx_send);
    // Top byte of the shifter is on the link
    assign data_fib_to_spi      = shift_q[fib_pkg::tx_w-1 -: fib_pkg::byte_w];

endmodule

`default_nettype wire

// ==== source/fib_table.sv ====
// FIB top for interest packets only; learn and query paths are independent and should not overlap
`default_nettype none
`timescale 1ns/1ps

module fib_table (
    input  logic                         clk,
    input  logic                         rst,
    // SPI to FIB
    input  logic                         rx_valid,
    input  logic [fib_pkg::byte_w-1:0]   data_spi_to_fib,
    // PIT to FIB
    input  logic                         fib_out_bit,
    input  logic [fib_pkg::prefix_w-1:0] pit_in_prefix,
    input  logic [fib_pkg::byte_w-1:0]   pit_in_metadata,
    // FIB to PIT
    output logic [fib_pkg::prefix_w-1:0] pit_out_prefix,
    output logic [fib_pkg::byte_w-1:0]   pit_out_metadata,
    output logic                         prefix_ready,
    // FIB to SPI
    output logic                         fib_to_spi_data_flag,
    output logic [fib_pkg::byte_w-1:0]   data_fib_to_spi
);

    // Learn port
    logic                         learn_en;
    logic [fib_pkg::prefix_w-1:0] learn_prefix;
    logic [fib_pkg::len_w-1:0]    learn_len;

    // Lookup port
    logic [fib_pkg::prefix_w-1:0] lookup_prefix;
    logic [fib_pkg::len_w-1:0]    lookup_len;
    logic                         lookup_hit;

    // Search to serializer
    logic                         tx_busy;
    logic                         result_valid;
    logic [fib_pkg::byte_w-1:0]   result_metadata;
    logic [fib_pkg::prefix_w-1:0] result_total;
    logic [fib_pkg::prefix_w-1:0] result_match;

    prefix_rx u_prefix_rx (
        .clk              (clk),
        .rst              (rst),
        .rx_valid         (rx_valid),
        .data_spi_to_fib  (data_spi_to_fib),
        .pit_out_prefix   (pit_out_prefix),
        .pit_out_metadata (pit_out_metadata),
        .prefix_ready     (prefix_ready),
        .learn_en         (learn_en),
        .learn_prefix     (learn_prefix),
        .learn_len        (learn_len)
    );

    fib_valid_table u_valid_table (
        .clk           (clk),
        .rst           (rst),
        .learn_en      (learn_en),
        .learn_prefix  (learn_prefix),
        .learn_len     (learn_len),
        .lookup_prefix (lookup_prefix),
        .lookup_len    (lookup_len),
        .lookup_hit    (lookup_hit)
    );

    lpm_search u_lpm_search (
        .clk             (clk),
        .rst             (rst),
        .fib_out_bit     (fib_out_bit),
        .pit_in_prefix   (pit_in_prefix),
        .pit_in_metadata (pit_in_metadata),
        .lookup_hit      (lookup_hit),
        .lookup_prefix   (lookup_prefix),
        .lookup_len      (lookup_len),
        .tx_busy         (tx_busy),
        .result_valid    (result_valid),
        .result_metadata (result_metadata),
        .result_total    (result_total),
        .result_match    (result_match)
    );

    spi_result_tx u_result_tx (
        .clk                  (clk),
        .rst                  (rst),
        .result_valid         (result_valid),
        .result_metadata      (result_metadata),
        .result_total         (result_total),
        .result_match         (result_match),
        .tx_busy              (tx_busy),
        .fib_to_spi_data_flag (fib_to_spi_data_flag),
        .data_fib_to_spi      (data_fib_to_spi)
    );

endmodule

`default_nettype wire

// ==== tests/tb_fib_table.sv ====
// Runs from the project root to find tests/fib_vectors.txt; learns and queries never overlap in time
`default_nettype none
`timescale 1ns/1ps

module tb_fib_table;

    localparam int half_period  = 5;
    localparam int drive_delay  = 1;
    localparam int reset_cycles = 10;
    // Longest search is 128 cycles plus the handoff
    localparam int flag_wait    = 300;
    localparam int learn_idle   = 4;

    logic                         clk;
    logic                         rst;
    logic                         rx_valid;
    logic [fib_pkg::byte_w-1:0]   data_spi_to_fib;
    logic                         fib_out_bit;
    logic [fib_pkg::prefix_w-1:0] pit_in_prefix;
    logic [fib_pkg::byte_w-1:0]   pit_in_metadata;
    logic [fib_pkg::prefix_w-1:0] pit_out_prefix;
    logic [fib_pkg::byte_w-1:0]   pit_out_metadata;
    logic                         prefix_ready;
    logic                         fib_to_spi_data_flag;
    logic [fib_pkg::byte_w-1:0]   data_fib_to_spi;

    // Records from the vectors file, one entry per line
    logic [7:0]  rec_kind   [$];
    logic [7:0]  rec_meta   [$];
    logic [63:0] rec_prefix [$];
    logic [63:0] rec_match  [$];
    int          num_records;
    bit          loaded;

    int value_errors;
    int protocol_errors;

    fib_table u_fib_table (
        .clk                  (clk),
        .rst                  (rst),
        .rx_valid             (rx_valid),
        .data_spi_to_fib      (data_spi_to_fib),
        .fib_out_bit          (fib_out_bit),
        .pit_in_prefix        (pit_in_prefix),
        .pit_in_metadata      (pit_in_metadata),
        .pit_out_prefix       (pit_out_prefix),
        .pit_out_metadata     (pit_out_metadata),
        .prefix_ready         (prefix_ready),
        .fib_to_spi_data_flag (fib_to_spi_data_flag),
        .data_fib_to_spi      (data_fib_to_spi)
    );

    always #(half_period) clk = ~clk;

    // Step to the drive point just after the next rising edge
    task automatic next_cycle();
        @(posedge clk);
        #(drive_delay);
    endtask

    // Comment lines start with a lone # token
    task automatic load_vectors();
        int               fd;
        int               code;
        logic [7:0]       tok;
        logic [8*128-1:0] rest;
        logic [63:0]      f_meta;
        logic [63:0]      f_prefix;
        logic [63:0]      f_match;
        fd = $fopen("tests/fib_vectors.txt", "r");
        if (fd == 0) begin
            protocol_errors++;
            $display("Could not open tests/fib_vectors.txt");
            return;
        end
        code = $fscanf(fd, "%s", tok);
        while (code == 1) begin
            if (tok == "#") begin
                code = $fgets(rest, fd);
            end else if (tok == "L" || tok == "Q") begin
                f_match = '0;
                if (tok == "L") begin
                    code = $fscanf(fd, "%h %h", f_meta, f_prefix);
                    code = code + 1;
                end else begin
                    code = $fscanf(fd, "%h %h %h", f_meta, f_prefix, f_match);
                end
                if (code != 3) begin
                    protocol_errors++;
                    $display("Record %0d in the vectors file has missing fields", num_records);
                end
                rec_kind.push_back(tok);
                rec_meta.push_back(f_meta[7:0]);
                rec_prefix.push_back(f_prefix);
                rec_match.push_back(f_match);
                num_records++;
            end else begin
                protocol_errors++;
                $display("Unknown record type %s in the vectors file", tok);
                code = $fgets(rest, fd);
            end
            code = $fscanf(fd, "%s", tok);
        end
        $fclose(fd);
    endtask

    // rx_valid cycle, metadata byte, 8 prefix bytes MSB first, then idle
    task automatic send_learn(input logic [7:0] meta, input logic [63:0] prefix);
        int pulses;
        rx_valid = 1'b1;
        next_cycle();
        rx_valid        = 1'b0;
        data_spi_to_fib = meta;
        for (int i = 0; i < fib_pkg::prefix_bytes; i++) begin
            next_cycle();
            data_spi_to_fib = prefix[(7 - i) * 8 +: 8];
        end
        pulses = 0;
        // Ready pulse is due in the first of these cycles
        for (int c = 0; c < learn_idle + 1; c++) begin
            next_cycle();
            data_spi_to_fib = '0;
            if (prefix_ready) begin
                pulses++;
                assert (pit_out_prefix == prefix) else begin
                    value_errors++;
                    $display("FAIL %0t: pit_out_prefix %h, expected %h",
                             $time, pit_out_prefix, prefix);
                end
                assert (pit_out_metadata == meta) else begin
                    value_errors++;
                    $display("FAIL %0t: pit_out_metadata %h, expected %h",
                             $time, pit_out_metadata, meta);
                end
            end
        end
        assert (pulses == 1) else begin
            protocol_errors++;
            $display("Learn of prefix %h gave %0d ready pulses instead of one", prefix, pulses);
        end
    endtask

    // One-cycle fib_out_bit, then collect the 17-byte result stream
    task automatic run_query(input logic [7:0] meta, input logic [63:0] prefix,
                             input logic [63:0] match);
        logic [fib_pkg::tx_w-1:0] stream;
        int                       waited;
        int                       high_run;
        bit                       dropped;
        fib_out_bit     = 1'b1;
        pit_in_prefix   = prefix;
        pit_in_metadata = meta;
        next_cycle();
        fib_out_bit = 1'b0;
        waited      = 0;
        while (!fib_to_spi_data_flag && waited < flag_wait) begin
            next_cycle();
            waited++;
        end
        assert (fib_to_spi_data_flag) else begin
            protocol_errors++;
            $display("No result stream for query %h within %0d cycles", prefix, flag_wait);
        end
        if (fib_to_spi_data_flag) begin
            stream   = {{(fib_pkg::tx_w - 8){1'b0}}, data_fib_to_spi};
            high_run = 1;
            dropped  = 1'b0;
            for (int n = 1; n < fib_pkg::tx_bytes; n++) begin
                next_cycle();
                if (fib_to_spi_data_flag && !dropped) begin
                    high_run++;
                end else begin
                    dropped = 1'b1;
                end
                stream = {stream[fib_pkg::tx_w-9:0], data_fib_to_spi};
            end
            assert (high_run == fib_pkg::tx_bytes) else begin
                protocol_errors++;
                $display("Result flag for query %h dropped after %0d cycles", prefix, high_run);
            end
            // Flag must fall right after the last byte
            next_cycle();
            assert (!fib_to_spi_data_flag) else begin
                protocol_errors++;
                $display("Result flag for query %h stayed high past 17 cycles", prefix);
            end
            assert (stream[135:128] == meta) else begin
                value_errors++;
                $display("FAIL %0t: result metadata %h, expected %h",
                         $time, stream[135:128], meta);
            end
            assert (stream[127:64] == prefix) else begin
                value_errors++;
                $display("FAIL %0t: result full prefix %h, expected %h",
                         $time, stream[127:64], prefix);
            end
            assert (stream[63:0] == match) else begin
                value_errors++;
                $display("FAIL %0t: matched prefix %h for query %h, expected %h",
                         $time, stream[63:0], prefix, match);
            end
        end
    endtask

    initial begin : main
        clk             = 1'b0;
        rst             = 1'b1;
        rx_valid        = 1'b0;
        data_spi_to_fib = '0;
        fib_out_bit     = 1'b0;
        pit_in_prefix   = '0;
        pit_in_metadata = '0;
        value_errors    = 0;
        protocol_errors = 0;
        num_records     = 0;
        loaded          = 1'b0;
        load_vectors();
        loaded = 1'b1;
        assert (num_records > 0) else begin
            protocol_errors++;
            $display("The vectors file held no records");
        end
        repeat (reset_cycles) @(posedge clk);
        #(drive_delay);
        rst = 1'b0;
        // Outputs quiet before any stimulus
        next_cycle();
        assert (!prefix_ready && !fib_to_spi_data_flag) else begin
            value_errors++;
            $display("FAIL %0t: prefix_ready %b or result flag %b high after reset",
                     $time, prefix_ready, fib_to_spi_data_flag);
        end
        for (int r = 0; r < num_records; r++) begin
            if (rec_kind[r] == "L") begin
                send_learn(rec_meta[r], rec_prefix[r]);
            end else begin
                run_query(rec_meta[r], rec_prefix[r], rec_match[r]);
            end
            next_cycle();
        end
        $display("Errors: %0d value, %0d protocol", value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    // Budget grows with the number of records
    initial begin : watchdog
        wait (loaded);
        repeat (num_records * 400 + 1000) @(posedge clk);
        $display("Timeout after %0d cycles, the run did not finish", num_records * 400 + 1000);
        $display("Errors: %0d value, %0d protocol", value_errors, protocol_errors);
        $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tests/fib_vectors.txt ====
# L metadata prefix : learn through SPI, metadata bits 5 to 0 give the length
# Q metadata prefix expected_match : query through fib_out_bit
L 90 ABCD123456789ABC
L 18 123456FFEEDDCCBB
L 60 ABCDEF0100C0FFEE
L C8 5A5A5A5A5A5A5A5A
# Exact hit at length 32
Q 20 ABCDEF0199998888 ABCDEF0100000000
# Length 40 falls back to the length 32 entry
Q 68 ABCDEF0177665544 ABCDEF0100000000
# Length 24 misses the 123456 entry and lands on ABCD
Q 18 ABCD990011223344 ABCD000000000000
# Differs from the length 32 entry in its last bits
Q A0 ABCDEF0200000001 ABCD000000000000
# Nothing learned under ABCE
Q 14 ABCE000000000000 0000000000000000
Q 08 5A00112233445566 5A00000000000000
# Length 63 walks all the way down to 24
Q 3F 123456789ABCDEF0 1234560000000000
Q 00 FFFFFFFFFFFFFFFF 0000000000000000
Q CC FFF0000000000000 0000000000000000
# Short entry learned late, then found
L 04 F000000000000000
Q 0C F123456789ABCDEF F000000000000000

// ==== vlog.f ====
source/fib_pkg.sv
source/prefix_hash.sv
source/fib_valid_table.sv
source/prefix_rx.sv
source/lpm_search.sv
source/spi_result_tx.sv
source/fib_table.sv
tests/tb_fib_table.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --assert --timescale 1ns/1ps -f vlog.f --top-module tb_fib_table -Mdir obj_dir -o sim_fib
	./obj_dir/sim_fib | tee sim.log
	grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log
